// File: hw/spi_defines.svh
`ifndef SPI_DEFINES_SVH
`define SPI_DEFINES_SVH

// widest character the shift engine can move in one transfer.
`define SPI_MAX_CHAR 16

// width of the length field. A length of zero stands for SPI_MAX_CHAR bits.
`define SPI_CHAR_LEN_BITS 4

// width of the clock divider field.
`define SPI_DIV_BITS 8

`endif

// File: hw/spi_pkg.sv
`default_nettype none

`include "spi_defines.svh"

package spi_pkg;

  // one data word, used for transmit data, receive data and the response.
  typedef logic [`SPI_MAX_CHAR-1:0] spi_word_t;

  // character length. Zero means a full word.
  typedef logic [`SPI_CHAR_LEN_BITS-1:0] spi_len_t;

  // sclk half period is div + 1 clk cycles.
  typedef logic [`SPI_DIV_BITS-1:0] spi_div_t;

  // one command as handed over by the host.
  typedef struct packed {
    logic      lsb;
    logic      tx_negedge;
    logic      rx_negedge;
    spi_len_t  len;
    spi_div_t  div;
    spi_word_t data;
  } spi_cmd_t;

endpackage

`default_nettype wire

// File: hw/spi_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module spi_clock_gen (
  input  logic              clk,
  input  logic              rst,
  input  logic              run,
  input  spi_pkg::spi_div_t div,
  output logic              sclk,
  output logic              pos_edge,
  output logic              neg_edge
);

  spi_pkg::spi_div_t cnt;
  logic              sclk_next;

  // the level sclk takes on the next cycle. A strobe always runs one cycle
  // ahead of the edge it announces, so the next level is the current one
  // flipped by a pending strobe.
  assign sclk_next = sclk ^ (pos_edge | neg_edge);

  // ##########################################################################
  // half period counter and edge strobes
  // ##########################################################################

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cnt      <= '0;
      sclk     <= 1'b0;
      pos_edge <= 1'b0;
      neg_edge <= 1'b0;
    end else if (!run) begin
      // parked low with a full half period loaded for the next start.
      cnt      <= div;
      sclk     <= 1'b0;
      pos_edge <= 1'b0;
      neg_edge <= 1'b0;
    end else begin
      sclk <= sclk_next;
      if (cnt == '0) begin
        cnt      <= div;
        pos_edge <= ~sclk_next;
        neg_edge <= sclk_next;
      end else begin
        cnt      <= cnt - spi_pkg::spi_div_t'(1);
        pos_edge <= 1'b0;
        neg_edge <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/spi_shift.sv
`timescale 1ns/1ns
`default_nettype none

module spi_shift (
  input  logic               clk,
  input  logic               rst,
  input  logic               go,
  input  logic               pos_edge,
  input  logic               neg_edge,
  input  logic               rx_negedge,
  input  logic               tx_negedge,
  input  logic               lsb,
  input  spi_pkg::spi_len_t  len,
  input  spi_pkg::spi_word_t p_in,
  input  logic               miso,
  output logic               tip,
  output logic               last,
  output spi_pkg::spi_word_t p_out,
  output logic               mosi
);

  localparam int len_w = $bits(spi_pkg::spi_len_t);
  localparam logic [len_w:0] cnt_one = 1;

  logic [len_w:0]   full_len;
  logic [len_w:0]   cnt;
  logic [len_w:0]   cnt_eff;
  logic [len_w:0]   tx_pos;
  logic [len_w:0]   rx_pos;
  logic [len_w-1:0] tx_idx;
  logic [len_w-1:0] rx_idx;
  logic             tx_strobe;
  logic             rx_strobe;

  // a zero length field selects a full word.
  assign full_len = {(len == '0), len};

  // while idle the counter may still hold the previous transfer, so the
  // first bit is picked from the fresh length instead.
  assign cnt_eff = tip ? cnt : full_len;

  // ##########################################################################
  // bit selection
  // ##########################################################################

  // cnt is the number of rising edges still to come. The transmit position
  // is the same for both edges. A rising edge launch simply repeats the bit
  // that was presented while idle.
  assign tx_pos = lsb ? full_len - cnt_eff : cnt_eff - cnt_one;

  // a falling edge sample sees the counter already stepped by the rising
  // edge before it.
  assign rx_pos = lsb ? full_len - (rx_negedge ? cnt + cnt_one : cnt)
                      : (rx_negedge ? cnt : cnt - cnt_one);

  assign tx_idx = tx_pos[len_w-1:0];
  assign rx_idx = rx_pos[len_w-1:0];

  assign tx_strobe = tx_negedge ? neg_edge : pos_edge;
  assign rx_strobe = rx_negedge ? neg_edge : pos_edge;

  // ##########################################################################
  // control
  // ##########################################################################

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cnt  <= '0;
      last <= 1'b0;
    end else if (!tip) begin
      cnt  <= full_len;
      last <= 1'b0;
    end else if (pos_edge && !last) begin
      cnt  <= cnt - cnt_one;
      last <= (cnt == cnt_one);
    end
  end

  // the transfer closes on the falling edge that follows the final rising
  // edge, so sclk is back low when tip drops.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      tip <= 1'b0;
    end else if (!tip) begin
      tip <= go;
    end else if (last && neg_edge) begin
      tip <= 1'b0;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      mosi <= 1'b0;
    end else if (!tip || (tx_strobe && !last)) begin
      mosi <= p_in[tx_idx];
    end
  end

  // only bits below the length are ever written into the receive word.
  always_ff @(posedge clk) begin
    if (go && !tip) begin
      p_out <= '0;
    end else if (tip && rx_strobe) begin
      p_out[rx_idx] <= miso;
    end
  end

endmodule

`default_nettype wire

// File: hw/spi_transfer_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module spi_transfer_ctrl (
  input  logic               clk,
  input  logic               rst,
  input  logic               cmd_req,
  input  logic               cmd_lsb,
  input  logic               cmd_tx_negedge,
  input  logic               cmd_rx_negedge,
  input  spi_pkg::spi_len_t  cmd_len,
  input  spi_pkg::spi_div_t  cmd_div,
  input  spi_pkg::spi_word_t cmd_data,
  output logic               cmd_ack,
  output spi_pkg::spi_word_t rsp_data,
  output logic               run,
  output spi_pkg::spi_div_t  div,
  output logic               go,
  output logic               lsb,
  output logic               tx_negedge,
  output logic               rx_negedge,
  output spi_pkg::spi_len_t  len,
  output spi_pkg::spi_word_t p_in,
  input  logic               tip,
  input  logic               last,
  input  spi_pkg::spi_word_t p_out,
  output logic               ss_n
);

  typedef enum logic [2:0] {
    st_idle,
    st_start,
    st_busy,
    st_done,
    st_release
  } state_t;

  state_t             state;
  spi_pkg::spi_cmd_t  cmd;
  logic               xfer_end;

  // last is still set in the one cycle after tip has dropped.
  assign xfer_end = !tip && last;

  // the clock runs from the go pulse until the engine reports the end.
  assign run = (state == st_busy) && !xfer_end;

  assign lsb        = cmd.lsb;
  assign tx_negedge = cmd.tx_negedge;
  assign rx_negedge = cmd.rx_negedge;
  assign len        = cmd.len;
  assign div        = cmd.div;
  assign p_in       = cmd.data;

  // ##########################################################################
  // handshake FSM
  // ##########################################################################

  // reset lands in st_release so a request is only taken once it has been
  // seen low.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state   <= st_release;
      cmd     <= '0;
      go      <= 1'b0;
      ss_n    <= 1'b1;
      cmd_ack <= 1'b0;
    end else begin
      go <= 1'b0;
      case (state)
        st_idle: begin
          if (cmd_req) begin
            cmd   <= '{lsb: cmd_lsb, tx_negedge: cmd_tx_negedge,
                       rx_negedge: cmd_rx_negedge, len: cmd_len,
                       div: cmd_div, data: cmd_data};
            state <= st_start;
          end
        end
        st_start: begin
          ss_n  <= 1'b0;
          go    <= 1'b1;
          state <= st_busy;
        end
        st_busy: begin
          if (xfer_end) begin
            ss_n    <= 1'b1;
            cmd_ack <= 1'b1;
            state   <= st_done;
          end
        end
        st_done: begin
          if (!cmd_req) begin
            cmd_ack <= 1'b0;
            state   <= st_release;
          end
        end
        st_release: begin
          if (!cmd_req) state <= st_idle;
        end
        default: state <= st_release;
      endcase
    end
  end

  // the response word is held for as long as the acknowledge stays up.
  always_ff @(posedge clk) begin
    if (state == st_busy && xfer_end) begin
      rsp_data <= p_out;
    end
  end

endmodule

`default_nettype wire

// File: hw/spi_master.sv
`timescale 1ns/1ns
`default_nettype none

module spi_master (
  input  logic               clk,
  input  logic               rst,
  input  logic               cmd_req,
  input  logic               cmd_lsb,
  input  logic               cmd_tx_negedge,
  input  logic               cmd_rx_negedge,
  input  spi_pkg::spi_len_t  cmd_len,
  input  spi_pkg::spi_div_t  cmd_div,
  input  spi_pkg::spi_word_t cmd_data,
  output logic               cmd_ack,
  output spi_pkg::spi_word_t rsp_data,
  output logic               sclk,
  output logic               mosi,
  input  logic               miso,
  output logic               ss_n
);

  logic               run;
  spi_pkg::spi_div_t  div;
  logic               go;
  logic               lsb;
  logic               tx_negedge;
  logic               rx_negedge;
  spi_pkg::spi_len_t  len;
  spi_pkg::spi_word_t p_in;
  spi_pkg::spi_word_t p_out;
  logic               pos_edge;
  logic               neg_edge;
  logic               tip;
  logic               last;

  spi_transfer_ctrl u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .cmd_req        (cmd_req),
    .cmd_lsb        (cmd_lsb),
    .cmd_tx_negedge (cmd_tx_negedge),
    .cmd_rx_negedge (cmd_rx_negedge),
    .cmd_len        (cmd_len),
    .cmd_div        (cmd_div),
    .cmd_data       (cmd_data),
    .cmd_ack        (cmd_ack),
    .rsp_data       (rsp_data),
    .run            (run),
    .div            (div),
    .go             (go),
    .lsb            (lsb),
    .tx_negedge     (tx_negedge),
    .rx_negedge     (rx_negedge),
    .len            (len),
    .p_in           (p_in),
    .tip            (tip),
    .last           (last),
    .p_out          (p_out),
    .ss_n           (ss_n)
  );

  spi_clock_gen u_clock_gen (
    .clk      (clk),
    .rst      (rst),
    .run      (run),
    .div      (div),
    .sclk     (sclk),
    .pos_edge (pos_edge),
    .neg_edge (neg_edge)
  );

  spi_shift u_shift (
    .clk        (clk),
    .rst        (rst),
    .go         (go),
    .pos_edge   (pos_edge),
    .neg_edge   (neg_edge),
    .rx_negedge (rx_negedge),
    .tx_negedge (tx_negedge),
    .lsb        (lsb),
    .len        (len),
    .p_in       (p_in),
    .miso       (miso),
    .tip        (tip),
    .last       (last),
    .p_out      (p_out),
    .mosi       (mosi)
  );

endmodule

`default_nettype wire

// File: testbench/spi_master_chk.sv
`timescale 1ns/1ns
`default_nettype none

module spi_master_chk (
  input logic clk,
  input logic rst,
  input logic cmd_req,
  input logic cmd_ack,
  input logic sclk,
  input logic mosi,
  input logic ss_n
);

  // ##########################################################################
  // handshake and bus protocol
  // ##########################################################################

  ack_rise_with_req: assert property (@(posedge clk) disable iff (rst)
    $rose(cmd_ack) |-> cmd_req)
    else $error("cmd_ack rose while cmd_req was low");

  ack_fall_after_req: assert property (@(posedge clk) disable iff (rst)
    $fell(cmd_ack) |-> !$past(cmd_req))
    else $error("cmd_ack fell before cmd_req was seen low");

  sclk_idle_low: assert property (@(posedge clk) disable iff (rst)
    ss_n |-> !sclk)
    else $error("sclk not low while ss_n is high");

  // mosi moves together with an sclk edge once the slave is selected.
  mosi_on_edge: assert property (@(posedge clk) disable iff (rst)
    (!ss_n && !$past(ss_n) && $changed(mosi)) |-> $changed(sclk))
    else $error("mosi changed away from an sclk edge");

endmodule

bind spi_master spi_master_chk u_chk (
  .clk     (clk),
  .rst     (rst),
  .cmd_req (cmd_req),
  .cmd_ack (cmd_ack),
  .sclk    (sclk),
  .mosi    (mosi),
  .ss_n    (ss_n)
);

`default_nettype wire

// File: testbench/spi_master_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "spi_defines.svh"

module spi_master_tb;

  logic               clk;
  logic               rst;
  logic               cmd_req;
  logic               cmd_lsb;
  logic               cmd_tx_negedge;
  logic               cmd_rx_negedge;
  spi_pkg::spi_len_t  cmd_len;
  spi_pkg::spi_div_t  cmd_div;
  spi_pkg::spi_word_t cmd_data;
  logic               cmd_ack;
  spi_pkg::spi_word_t rsp_data;
  logic               sclk;
  logic               mosi;
  logic               miso = 1'b0;
  logic               ss_n;

  spi_pkg::spi_cmd_t  pat_cmd[$];
  spi_pkg::spi_word_t pat_slave[$];
  spi_pkg::spi_word_t pat_exp_mosi[$];
  spi_pkg::spi_word_t pat_exp_rsp[$];

  // the slave model works from the command of the transfer in flight.
  spi_pkg::spi_cmd_t  cur;
  spi_pkg::spi_word_t slave_word;
  spi_pkg::spi_word_t mosi_word = '0;
  int                 edge_cnt = 0;
  logic               sclk_q = 1'b0;
  logic               ss_q = 1'b1;

  integer             seed;
  int unsigned        cycles = 0;
  int unsigned        limit = 0;

  spi_master DUT (
    .clk            (clk),
    .rst            (rst),
    .cmd_req        (cmd_req),
    .cmd_lsb        (cmd_lsb),
    .cmd_tx_negedge (cmd_tx_negedge),
    .cmd_rx_negedge (cmd_rx_negedge),
    .cmd_len        (cmd_len),
    .cmd_div        (cmd_div),
    .cmd_data       (cmd_data),
    .cmd_ack        (cmd_ack),
    .rsp_data       (rsp_data),
    .sclk           (sclk),
    .mosi           (mosi),
    .miso           (miso),
    .ss_n           (ss_n)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic int char_len(spi_pkg::spi_len_t len);
    return (len == '0) ? `SPI_MAX_CHAR : int'(len);
  endfunction

  // position in the word of the k-th bit on the wire.
  function automatic int bit_pos(logic lsb, int n, int k);
    return lsb ? k : n - 1 - k;
  endfunction

  function automatic logic wire_bit(spi_pkg::spi_word_t word, spi_pkg::spi_cmd_t c, int k);
    int n;
    n = char_len(c.len);
    if (k >= n) return 1'b0;
    return word[bit_pos(c.lsb, n, k)];
  endfunction

  // ##########################################################################
  // slave model
  // ##########################################################################

  // the receive edge of the master is also the edge where the slave samples
  // mosi, since the patterns always use opposite edges.
  always @(posedge clk) begin
    sclk_q <= sclk;
    ss_q   <= ss_n;
    if (ss_n !== 1'b0) begin
      edge_cnt <= 0;
      miso     <= wire_bit(slave_word, cur, 0);
    end else if (ss_q) begin
      mosi_word <= '0;
    end else if (sclk !== sclk_q && sclk !== cur.rx_negedge) begin
      if (edge_cnt < char_len(cur.len)) begin
        mosi_word[bit_pos(cur.lsb, char_len(cur.len), edge_cnt)] <= mosi;
      end
      edge_cnt <= edge_cnt + 1;
      miso     <= wire_bit(slave_word, cur, edge_cnt + 1);
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit != 0 && cycles >= limit) begin
      $display("timeout, the transfers did not finish within %0d clock cycles", limit);
      $display("test failed");
      $fatal(1);
    end
  end

  // ##########################################################################
  // checks
  // ##########################################################################

  task automatic check_word(string name, spi_pkg::spi_word_t exp, spi_pkg::spi_word_t act);
    if (act !== exp) begin
      $display("Error: %s expected %h actual %h", name, exp, act);
      $display("test failed");
      $fatal(1);
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("Error: %s expected %b actual %b", name, exp, act);
      $display("test failed");
      $fatal(1);
    end
  endtask

  task automatic read_patterns();
    int                 fd;
    int                 rc;
    string              line;
    logic               f_lsb;
    logic               f_tx;
    logic               f_rx;
    spi_pkg::spi_len_t  f_len;
    spi_pkg::spi_div_t  f_div;
    spi_pkg::spi_word_t f_data;
    spi_pkg::spi_word_t f_slave;
    spi_pkg::spi_word_t f_mosi;
    spi_pkg::spi_word_t f_rsp;
    spi_pkg::spi_cmd_t  c;
    fd = $fopen("testbench/spi_master_patterns.txt", "r");
    if (fd == 0) begin
      $display("could not open the pattern file");
      $display("test failed");
      $fatal(1);
    end
    while (!$feof(fd)) begin
      line = "";
      rc = $fgets(line, fd);
      if (line.len() < 2 || line[0] == 8'h23) continue;
      rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h", f_lsb, f_tx, f_rx, f_len,
                   f_div, f_data, f_slave, f_mosi, f_rsp);
      if (rc == 9) begin
        c.lsb        = f_lsb;
        c.tx_negedge = f_tx;
        c.rx_negedge = f_rx;
        c.len        = f_len;
        c.div        = f_div;
        c.data       = f_data;
        pat_cmd.push_back(c);
        pat_slave.push_back(f_slave);
        pat_exp_mosi.push_back(f_mosi);
        pat_exp_rsp.push_back(f_rsp);
      end
    end
    $fclose(fd);
  endtask

  task automatic run_pattern(int i);
    int unsigned        delay;
    int unsigned        hold;
    spi_pkg::spi_cmd_t  c;
    c = pat_cmd[i];
    delay = $unsigned($random(seed)) % 8;
    repeat (delay) @(posedge clk);
    cur            <= c;
    slave_word     <= pat_slave[i];
    cmd_lsb        <= c.lsb;
    cmd_tx_negedge <= c.tx_negedge;
    cmd_rx_negedge <= c.rx_negedge;
    cmd_len        <= c.len;
    cmd_div        <= c.div;
    cmd_data       <= c.data;
    cmd_req        <= 1'b1;
    do @(posedge clk); while (cmd_ack !== 1'b1);
    check_word($sformatf("pattern %0d rsp_data", i), pat_exp_rsp[i], rsp_data);
    check_word($sformatf("pattern %0d mosi word", i), pat_exp_mosi[i], mosi_word);
    check_word($sformatf("pattern %0d sclk edges", i),
               spi_pkg::spi_word_t'(char_len(c.len)), spi_pkg::spi_word_t'(edge_cnt));
    // the host keeps the request up for a while. Nothing may move meanwhile.
    hold = $unsigned($random(seed)) % 6;
    repeat (hold) begin
      @(posedge clk);
      check_bit($sformatf("pattern %0d held cmd_ack", i), 1'b1, cmd_ack);
      check_word($sformatf("pattern %0d held rsp_data", i), pat_exp_rsp[i], rsp_data);
      check_bit($sformatf("pattern %0d held ss_n", i), 1'b1, ss_n);
    end
    cmd_req <= 1'b0;
    do @(posedge clk); while (cmd_ack !== 1'b0);
    check_bit($sformatf("pattern %0d ss_n after release", i), 1'b1, ss_n);
  endtask

  // ##########################################################################
  // main sequence
  // ##########################################################################

  initial begin
    seed           = 32'h8420_ee45;
    rst            = 1'b1;
    cmd_req        = 1'b0;
    cmd_lsb        = 1'b0;
    cmd_tx_negedge = 1'b0;
    cmd_rx_negedge = 1'b0;
    cmd_len        = '0;
    cmd_div        = '0;
    cmd_data       = '0;
    cur            = '0;
    slave_word     = '0;
    read_patterns();
    if (pat_cmd.size() == 0) begin
      $display("the pattern file holds no transfers");
      $display("test failed");
      $fatal(1);
    end
    limit = 20;
    foreach (pat_cmd[i]) begin
      limit = limit + 2 * char_len(pat_cmd[i].len) * (int'(pat_cmd[i].div) + 1) + 40;
    end
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    check_bit("reset ss_n", 1'b1, ss_n);
    check_bit("reset sclk", 1'b0, sclk);
    check_bit("reset cmd_ack", 1'b0, cmd_ack);
    foreach (pat_cmd[i]) begin
      run_pattern(i);
    end
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: spi_master.f
+incdir+hw
hw/spi_pkg.sv
hw/spi_clock_gen.sv
hw/spi_shift.sv
hw/spi_transfer_ctrl.sv
hw/spi_master.sv
testbench/spi_master_chk.sv
testbench/spi_master_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the SPI master testbench with Verilator, run it, and look for the pass line.
cd "$(dirname "$0")" &&
  verilator --binary --assert --timing --top-module spi_master_tb \
    -f spi_master.f -o spi_master_sim &&
  ./obj_dir/spi_master_sim | tee /dev/stderr | grep -x "test passed" > /dev/null &&
  echo "simulation ok" ||
  { echo "simulation not ok"; exit 1; }

// File: testbench/spi_master_patterns.txt
# columns, all hex: lsb tx_negedge rx_negedge len div cmd_data slave_word exp_mosi exp_rsp
# a len of 0 is a 16-bit character, expected words hold only the low len bits
0 1 0 8 1 00A5 003C 00A5 003C
0 1 0 0 0 BEEF 1234 BEEF 1234
0 0 1 8 1 12C3 5A96 00C3 0096
0 0 1 0 7 8001 F00D 8001 F00D
1 1 0 5 0 FFF5 0013 0015 0013
1 0 1 5 1 000A FFEB 000A 000B
1 1 0 C 7 3ABC 9123 0ABC 0123
1 0 1 C 0 0F0F A5A5 0F0F 05A5
0 1 0 4 7 0009 0006 0009 0006
0 0 1 1 0 0001 0001 0001 0001
1 1 0 0 1 C3A5 6E71 C3A5 6E71
0 0 1 F 0 FFFF 0000 7FFF 0000
